//--- rtl/lsu_replay_pkg.sv
/*
 * LSU replay path shared definitions
 * Address and tag widths, hazard kinds and the two-way decode of the
 * load instruction word
 */
`default_nettype none

package lsu_replay_pkg;

    localparam int ADDR_W     = 32;
    localparam int LINE_OFF_W = 6;
    localparam int LINE_W     = ADDR_W - LINE_OFF_W;  // Line address width
    localparam int TAG_W      = 4;
    localparam int IMM_W      = 12;

    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_PREFETCH = 7'b0010011;  // ORI with rd=x0

    typedef enum logic [1:0] {
        HAZ_NONE           = 2'd0,
        HAZ_L1D_CONFLICT   = 2'd1,
        HAZ_MISSU_FULL     = 2'd2,
        HAZ_MISSU_ASSIGNED = 2'd3
    } haz_t;

    // ------------------------------
    // Instruction word views
    // ------------------------------
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } load_view_t;

    typedef struct packed {
        logic [6:0]  imm_hi;   // Offset bits 11:5 over zero low bits
        logic [4:0]  hint;     // Prefetch kind select
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } pref_view_t;

    typedef union packed {
        load_view_t ld;
        pref_view_t pf;
    } lsu_inst_u;

endpackage

`default_nettype wire

//--- rtl/lsu_issue_sel.sv
/*
 * Issue select, stage 1 of the load pipe
 * Picks a re-issued load from the replay queue over a new request
 * and registers the winner into the pipe
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_issue_sel (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire logic                              i_req_valid,
    input  wire logic [lsu_replay_pkg::TAG_W-1:0]  i_req_tag,
    input  wire logic [lsu_replay_pkg::ADDR_W-1:0] i_req_base,
    input  wire logic [31:0]                       i_req_inst,
    input  wire logic                              i_rq_valid,
    input  wire logic [lsu_replay_pkg::TAG_W-1:0]  i_rq_tag,
    input  wire logic [lsu_replay_pkg::ADDR_W-1:0] i_rq_addr,
    input  wire logic                              i_rq_free_ge2,
    output logic                                   o_req_ready,
    output logic                                   o_rq_take,
    output logic                                   o_p1_valid,
    output logic [lsu_replay_pkg::TAG_W-1:0]       o_p1_tag,
    output logic [lsu_replay_pkg::ADDR_W-1:0]      o_p1_base,
    output logic [31:0]                            o_p1_inst,
    output logic                                   o_p1_replay
);

    logic w_take_new;

    // Replay always wins over a new load
    assign o_rq_take   = i_rq_valid;
    assign o_req_ready = !i_rq_valid && i_rq_free_ge2;
    assign w_take_new  = i_req_valid && o_req_ready;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_p1_valid <= 1'b0;
        end else begin
            o_p1_valid <= i_rq_valid || w_take_new;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rq_valid) begin
            o_p1_tag    <= i_rq_tag;
            o_p1_base   <= i_rq_addr;  // Full address already formed
            o_p1_replay <= 1'b1;
        end else if (w_take_new) begin
            o_p1_tag    <= i_req_tag;
            o_p1_base   <= i_req_base;
            o_p1_inst   <= i_req_inst;
            o_p1_replay <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_addr_stage.sv
/*
 * Address and hazard check, stage 2 of the load pipe
 * Forms the load address, checks the bank and the miss tracker, and
 * registers either a completion or a push into the replay queue
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_addr_stage #(
    parameter int MISSU_ENTRIES = 4
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire logic                              i_p1_valid,
    input  wire logic [lsu_replay_pkg::TAG_W-1:0]  i_p1_tag,
    input  wire logic [lsu_replay_pkg::ADDR_W-1:0] i_p1_base,
    input  wire logic [31:0]                       i_p1_inst,
    input  wire logic                              i_p1_replay,
    input  wire logic                              i_miss,
    input  wire logic                              i_l1d_busy,
    input  wire logic [MISSU_ENTRIES-1:0]          i_mt_match_oh,
    input  wire logic                              i_mt_full,
    output logic [lsu_replay_pkg::LINE_W-1:0]      o_mt_lookup_line,
    output logic                                   o_mt_alloc,
    output logic                                   o_haz_push,
    output logic [lsu_replay_pkg::TAG_W-1:0]       o_haz_tag,
    output logic [lsu_replay_pkg::ADDR_W-1:0]      o_haz_addr,
    output lsu_replay_pkg::haz_t                   o_haz_typ,
    output logic [MISSU_ENTRIES-1:0]               o_haz_missu_oh,
    output logic                                   o_done_valid,
    output logic [lsu_replay_pkg::TAG_W-1:0]       o_done_tag,
    output logic [lsu_replay_pkg::ADDR_W-1:0]      o_done_addr,
    output logic                                   o_done_miss
);

    localparam int AW = lsu_replay_pkg::ADDR_W;
    localparam int IW = lsu_replay_pkg::IMM_W;

    lsu_replay_pkg::lsu_inst_u w_inst;
    lsu_replay_pkg::haz_t      w_haz_typ;
    logic [AW-1:0]             w_imm;
    logic [AW-1:0]             w_addr;
    logic [MISSU_ENTRIES-1:0]  w_haz_oh;
    logic                      w_done;
    logic [lsu_replay_pkg::TAG_W-1:0] r_tag;
    logic [AW-1:0]             r_addr;

    // ------------------------------
    // Address forming
    // ------------------------------
    assign w_inst = i_p1_inst;

    always_comb begin
        case (w_inst.ld.opcode)
            lsu_replay_pkg::OPC_PREFETCH: w_imm = {{(AW-IW){w_inst.pf.imm_hi[6]}},
                                                   w_inst.pf.imm_hi, 5'b0};
            lsu_replay_pkg::OPC_LOAD:     w_imm = {{(AW-IW){w_inst.ld.imm[11]}}, w_inst.ld.imm};
            default:                      w_imm = '0;
        endcase
    end

    assign w_addr           = i_p1_replay ? i_p1_base : i_p1_base + w_imm;
    assign o_mt_lookup_line = w_addr[AW-1:lsu_replay_pkg::LINE_OFF_W];

    // ------------------------------
    // Hazard check in priority order
    // ------------------------------
    // Completes when the bank is free and a miss can take a refill entry
    assign w_done     = i_p1_valid && !i_l1d_busy &&
                        !(i_miss && (|i_mt_match_oh || i_mt_full));
    assign o_mt_alloc = w_done && i_miss;

    always_comb begin
        w_haz_typ = lsu_replay_pkg::HAZ_NONE;
        w_haz_oh  = '0;
        if (i_p1_valid) begin
            if (i_l1d_busy) begin
                w_haz_typ = lsu_replay_pkg::HAZ_L1D_CONFLICT;
            end else if (i_miss && |i_mt_match_oh) begin
                w_haz_typ = lsu_replay_pkg::HAZ_MISSU_ASSIGNED;
                w_haz_oh  = i_mt_match_oh;  // Wait on this refill
            end else if (i_miss && i_mt_full) begin
                w_haz_typ = lsu_replay_pkg::HAZ_MISSU_FULL;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_haz_push   <= 1'b0;
            o_done_valid <= 1'b0;
        end else begin
            o_haz_push   <= w_haz_typ != lsu_replay_pkg::HAZ_NONE;
            o_done_valid <= w_done;
        end
    end

    always_ff @(posedge i_clk) begin
        r_tag          <= i_p1_tag;
        r_addr         <= w_addr;
        o_haz_typ      <= w_haz_typ;
        o_haz_missu_oh <= w_haz_oh;
        o_done_miss    <= i_miss;
    end

    assign o_haz_tag   = r_tag;
    assign o_haz_addr  = r_addr;
    assign o_done_tag  = r_tag;
    assign o_done_addr = r_addr;

    // A load leaves stage 2 by exactly one of the two exits
    a_push_xor_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(o_haz_push && o_done_valid))
        else $error("stage 2 pushed and completed the same load");

    a_one_exit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_p1_valid |=> o_haz_push || o_done_valid)
        else $error("stage 2 dropped a load");

endmodule

`default_nettype wire

//--- rtl/lsu_replay_queue.sv
/*
 * Replay queue for hazarded loads
 * Circular buffer in arrival order. Only the head re-issues, once
 * the wake-up condition of its hazard kind holds
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_replay_queue #(
    parameter int RQ_DEPTH      = 8,
    parameter int MISSU_ENTRIES = 4
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire logic                              i_haz_push,
    input  wire logic [lsu_replay_pkg::TAG_W-1:0]  i_haz_tag,
    input  wire logic [lsu_replay_pkg::ADDR_W-1:0] i_haz_addr,
    input  wire lsu_replay_pkg::haz_t              i_haz_typ,
    input  wire logic [MISSU_ENTRIES-1:0]          i_haz_missu_oh,
    input  wire logic                              i_take,
    input  wire logic                              i_mt_full,
    input  wire logic                              i_mt_resolve_valid,
    input  wire logic [MISSU_ENTRIES-1:0]          i_mt_resolve_oh,
    input  wire logic [MISSU_ENTRIES-1:0]          i_mt_entry_valids,
    output logic                                   o_valid,
    output logic [lsu_replay_pkg::TAG_W-1:0]       o_tag,
    output logic [lsu_replay_pkg::ADDR_W-1:0]      o_addr,
    output logic                                   o_free_ge2
);

    localparam int PTR_W = $clog2(RQ_DEPTH);
    localparam int CNT_W = $clog2(RQ_DEPTH + 1);

    logic [lsu_replay_pkg::TAG_W-1:0]  r_tag   [RQ_DEPTH];
    logic [lsu_replay_pkg::ADDR_W-1:0] r_addr  [RQ_DEPTH];
    lsu_replay_pkg::haz_t              r_typ   [RQ_DEPTH];
    logic [MISSU_ENTRIES-1:0]          r_oh    [RQ_DEPTH];

    logic [PTR_W-1:0] r_head;
    logic [PTR_W-1:0] r_tail;
    logic [CNT_W-1:0] r_count;
    logic             w_empty;
    logic             w_wake;
    logic [MISSU_ENTRIES-1:0] w_head_oh;
    lsu_replay_pkg::haz_t     w_head_typ;

    assign w_empty    = r_count == '0;
    assign w_head_oh  = r_oh[r_head];
    assign w_head_typ = r_typ[r_head];

    // Two loads may already be in the pipe ahead of the queue
    assign o_free_ge2 = 32'(r_count) + 32'(i_haz_push) + 32'd2 <= 32'(RQ_DEPTH);

    // ------------------------------
    // Head wake-up
    // ------------------------------
    always_comb begin
        case (w_head_typ)
            lsu_replay_pkg::HAZ_L1D_CONFLICT:   w_wake = 1'b1;
            lsu_replay_pkg::HAZ_MISSU_FULL:     w_wake = !i_mt_full;
            lsu_replay_pkg::HAZ_MISSU_ASSIGNED: w_wake =
                (i_mt_resolve_valid && i_mt_resolve_oh == w_head_oh) ||
                ((w_head_oh & i_mt_entry_valids) == '0);  // Refill entry gone
            default:                            w_wake = 1'b0;
        endcase
    end

    assign o_valid = !w_empty && w_wake;
    assign o_tag   = r_tag[r_head];
    assign o_addr  = r_addr[r_head];

    // ------------------------------
    // Pointers and count
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_head  <= '0;
            r_tail  <= '0;
            r_count <= '0;
        end else begin
            if (i_haz_push) begin
                r_tail <= (32'(r_tail) == RQ_DEPTH - 1) ? '0 : r_tail + 1'b1;
            end
            if (i_take) begin
                r_head <= (32'(r_head) == RQ_DEPTH - 1) ? '0 : r_head + 1'b1;
            end
            case ({i_haz_push, i_take})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_haz_push) begin
            r_tag[r_tail]  <= i_haz_tag;
            r_addr[r_tail] <= i_haz_addr;
            r_typ[r_tail]  <= i_haz_typ;
            r_oh[r_tail]   <= i_haz_missu_oh;
        end
    end

    // Issue select must hold new loads off before the queue fills
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_haz_push |-> 32'(r_count) < RQ_DEPTH)
        else $error("replay push into a full queue");

    a_head_kind: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !w_empty |-> w_head_typ != lsu_replay_pkg::HAZ_NONE)
        else $error("replay queue head holds no hazard kind");

endmodule

`default_nettype wire

//--- rtl/lsu_miss_tracker.sv
/*
 * Miss tracker
 * Refill entries by line address. Allocates the lowest free entry and
 * resolves it with a one-hot pulse after a fixed latency
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_miss_tracker #(
    parameter int MISSU_ENTRIES = 4,
    parameter int REFILL_LAT    = 12
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire logic [lsu_replay_pkg::LINE_W-1:0] i_lookup_line,
    input  wire logic                              i_alloc,
    output logic [MISSU_ENTRIES-1:0]               o_match_oh,
    output logic                                   o_full,
    output logic                                   o_resolve_valid,
    output logic [MISSU_ENTRIES-1:0]               o_resolve_oh,
    output logic [MISSU_ENTRIES-1:0]               o_entry_valids
);

    localparam int CNT_W = $clog2(REFILL_LAT + 1);

    logic [MISSU_ENTRIES-1:0]          r_valid;
    logic [lsu_replay_pkg::LINE_W-1:0] r_line [MISSU_ENTRIES];
    logic [CNT_W-1:0]                  r_cnt  [MISSU_ENTRIES];
    logic [MISSU_ENTRIES-1:0]          w_alloc_oh;
    logic [MISSU_ENTRIES-1:0]          w_fin;

    always_comb begin
        w_alloc_oh = '0;
        for (int i = MISSU_ENTRIES - 1; i >= 0; i--) begin
            if (!r_valid[i]) w_alloc_oh = MISSU_ENTRIES'(1) << i;  // Lowest wins
        end
        for (int i = 0; i < MISSU_ENTRIES; i++) begin
            o_match_oh[i] = r_valid[i] && r_line[i] == i_lookup_line;
            w_fin[i]      = r_valid[i] && r_cnt[i] == '0;
        end
    end

    assign o_full         = &r_valid;
    assign o_entry_valids = r_valid;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_valid         <= '0;
            o_resolve_valid <= 1'b0;
        end else begin
            r_valid         <= (r_valid & ~w_fin) | (i_alloc ? w_alloc_oh : '0);
            o_resolve_valid <= |w_fin;
        end
    end

    always_ff @(posedge i_clk) begin
        o_resolve_oh <= w_fin;
        for (int i = 0; i < MISSU_ENTRIES; i++) begin
            if (i_alloc && w_alloc_oh[i]) begin
                r_line[i] <= i_lookup_line;
                r_cnt[i]  <= CNT_W'(REFILL_LAT - 1);
            end else if (r_valid[i] && r_cnt[i] != '0) begin
                r_cnt[i]  <= r_cnt[i] - 1'b1;
            end
        end
    end

    a_no_alloc_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_alloc |-> !o_full)
        else $error("miss tracker allocation while full");

endmodule

`default_nettype wire

//--- rtl/lsu_replay_top.sv
/*
 * Load path with replay queue
 * Issue select and address stage in a chain, with the replay queue
 * and the miss tracker beside them
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_replay_top #(
    parameter int RQ_DEPTH      = 8,
    parameter int MISSU_ENTRIES = 4,
    parameter int REFILL_LAT    = 12
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire logic                              i_req_valid,
    input  wire logic [lsu_replay_pkg::TAG_W-1:0]  i_req_tag,
    input  wire logic [lsu_replay_pkg::ADDR_W-1:0] i_req_base,
    input  wire logic [31:0]                       i_req_inst,
    output logic                                   o_req_ready,
    input  wire logic                              i_miss,
    input  wire logic                              i_l1d_busy,
    output logic                                   o_done_valid,
    output logic [lsu_replay_pkg::TAG_W-1:0]       o_done_tag,
    output logic [lsu_replay_pkg::ADDR_W-1:0]      o_done_addr,
    output logic                                   o_done_miss
);

    logic                              p1_valid, p1_replay;
    logic [lsu_replay_pkg::TAG_W-1:0]  p1_tag, haz_tag, rq_tag;
    logic [lsu_replay_pkg::ADDR_W-1:0] p1_base, haz_addr, rq_addr;
    logic [31:0]                       p1_inst;
    logic                              haz_push, rq_valid, rq_take, rq_free_ge2;
    lsu_replay_pkg::haz_t              haz_typ;
    logic [MISSU_ENTRIES-1:0]          haz_missu_oh, mt_match_oh;
    logic [MISSU_ENTRIES-1:0]          mt_resolve_oh, mt_entry_valids;
    logic [lsu_replay_pkg::LINE_W-1:0] mt_lookup_line;
    logic                              mt_alloc, mt_full, mt_resolve_valid;

    lsu_issue_sel u_issue_sel (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_req_valid(i_req_valid), .i_req_tag(i_req_tag),
        .i_req_base(i_req_base), .i_req_inst(i_req_inst),
        .i_rq_valid(rq_valid), .i_rq_tag(rq_tag), .i_rq_addr(rq_addr),
        .i_rq_free_ge2(rq_free_ge2),
        .o_req_ready(o_req_ready), .o_rq_take(rq_take),
        .o_p1_valid(p1_valid), .o_p1_tag(p1_tag), .o_p1_base(p1_base),
        .o_p1_inst(p1_inst), .o_p1_replay(p1_replay)
    );

    lsu_addr_stage #(.MISSU_ENTRIES(MISSU_ENTRIES)) u_addr_stage (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_p1_valid(p1_valid), .i_p1_tag(p1_tag), .i_p1_base(p1_base),
        .i_p1_inst(p1_inst), .i_p1_replay(p1_replay),
        .i_miss(i_miss), .i_l1d_busy(i_l1d_busy),
        .i_mt_match_oh(mt_match_oh), .i_mt_full(mt_full),
        .o_mt_lookup_line(mt_lookup_line), .o_mt_alloc(mt_alloc),
        .o_haz_push(haz_push), .o_haz_tag(haz_tag), .o_haz_addr(haz_addr),
        .o_haz_typ(haz_typ), .o_haz_missu_oh(haz_missu_oh),
        .o_done_valid(o_done_valid), .o_done_tag(o_done_tag),
        .o_done_addr(o_done_addr), .o_done_miss(o_done_miss)
    );

    lsu_replay_queue #(.RQ_DEPTH(RQ_DEPTH), .MISSU_ENTRIES(MISSU_ENTRIES)) u_replay_queue (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_haz_push(haz_push), .i_haz_tag(haz_tag), .i_haz_addr(haz_addr),
        .i_haz_typ(haz_typ), .i_haz_missu_oh(haz_missu_oh),
        .i_take(rq_take), .i_mt_full(mt_full),
        .i_mt_resolve_valid(mt_resolve_valid), .i_mt_resolve_oh(mt_resolve_oh),
        .i_mt_entry_valids(mt_entry_valids),
        .o_valid(rq_valid), .o_tag(rq_tag), .o_addr(rq_addr),
        .o_free_ge2(rq_free_ge2)
    );

    lsu_miss_tracker #(
        .MISSU_ENTRIES(MISSU_ENTRIES),
        .REFILL_LAT(REFILL_LAT)
    ) u_miss_tracker (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_lookup_line(mt_lookup_line), .i_alloc(mt_alloc),
        .o_match_oh(mt_match_oh), .o_full(mt_full),
        .o_resolve_valid(mt_resolve_valid), .o_resolve_oh(mt_resolve_oh),
        .o_entry_valids(mt_entry_valids)
    );

endmodule

`default_nettype wire

//--- testbench/tb_lsu_replay.sv
/*
 * Testbench for the load path with replay queue
 * Loads come from a trace file. A small cache model drives the miss and
 * bank-busy levels, and a scoreboard keyed by tag checks every completion
 */
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_replay;

    localparam int RQ_DEPTH      = 8;
    localparam int MISSU_ENTRIES = 4;
    localparam int REFILL_LAT    = 12;
    localparam int MAX_LINES     = 64;
    localparam int LW            = lsu_replay_pkg::LINE_W;
    localparam int OFF           = lsu_replay_pkg::LINE_OFF_W;

    logic        i_clk;
    logic        i_reset_n;
    logic        i_req_valid;
    logic [3:0]  i_req_tag;
    logic [31:0] i_req_base;
    logic [31:0] i_req_inst;
    logic        i_miss;
    logic        i_l1d_busy;
    logic        o_req_ready;
    logic        o_done_valid;
    logic [3:0]  o_done_tag;
    logic [31:0] o_done_addr;
    logic        o_done_miss;

    // Trace columns
    logic [31:0] tr_tag  [MAX_LINES];
    logic [31:0] tr_base [MAX_LINES];
    logic [31:0] tr_inst [MAX_LINES];
    logic [31:0] tr_addr [MAX_LINES];
    int          tr_miss [MAX_LINES];
    int          tr_bs   [MAX_LINES];
    int          tr_be   [MAX_LINES];
    int          n_lines;

    // Scoreboard keyed by tag
    logic [31:0] sb_addr [int];
    int          sb_miss [int];
    int          sb_cap  [int];
    int          sb_fast [int];
    int          sb_wait [int];  // Second load to a line in flight
    int          sb_ep   [int];
    int          sb_seq  [int];
    logic [LW-1:0] sb_line [int];

    // Cache model
    bit          miss_line [logic [LW-1:0]];
    bit          seen_line [logic [LW-1:0]];
    int          fill_edge [logic [LW-1:0]];
    int          line_done [logic [LW-1:0]];
    int          miss_done_q[$];
    int          busy_at [int];
    int          ep_cnt  [int];
    int          ep_last [int];
    int          cyc;

    lsu_replay_top #(
        .RQ_DEPTH(RQ_DEPTH),
        .MISSU_ENTRIES(MISSU_ENTRIES),
        .REFILL_LAT(REFILL_LAT)
    ) u_dut (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_req_valid(i_req_valid), .i_req_tag(i_req_tag),
        .i_req_base(i_req_base), .i_req_inst(i_req_inst),
        .o_req_ready(o_req_ready),
        .i_miss(i_miss), .i_l1d_busy(i_l1d_busy),
        .o_done_valid(o_done_valid), .o_done_tag(o_done_tag),
        .o_done_addr(o_done_addr), .o_done_miss(o_done_miss)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_fail("value check failed");
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    code;
        string s;
        fd = $fopen("testbench/lsu_replay_trace.txt", "r");
        if (fd == 0) report_fail("could not open the trace file");
        n_lines = 0;
        while (!$feof(fd)) begin
            code = $fgets(s, fd);
            if (code > 1 && s[0] != 8'h23) begin
                code = $sscanf(s, "%h %h %h %d %d %d %h", tr_tag[n_lines],
                               tr_base[n_lines], tr_inst[n_lines], tr_miss[n_lines],
                               tr_bs[n_lines], tr_be[n_lines], tr_addr[n_lines]);
                if (code == 7) begin
                    if (tr_miss[n_lines] != 0) miss_line[tr_addr[n_lines][31:OFF]] = 1'b1;
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------
    // Completion check
    // ------------------------------
    task automatic check_done();
        int            t;
        logic [LW-1:0] line;
        t = int'(o_done_tag);
        if (!sb_addr.exists(t)) report_fail("a completion arrived for a tag that is not in flight");
        line = sb_line[t];
        check_value("o_done_addr", o_done_addr, sb_addr[t]);
        check_value("o_done_miss", 32'(o_done_miss), 32'(sb_miss[t]));
        check_value("i_l1d_busy in stage 2", 32'(busy_at[cyc - 2]), 32'd0);
        if (sb_fast[t] != 0) check_value("hit latency", 32'(cyc - sb_cap[t]), 32'd2);
        if (sb_wait[t] != 0) begin
            check_value("refill wait", 32'(cyc >= line_done[line] + REFILL_LAT), 32'd1);
        end
        if (sb_miss[t] != 0) begin
            if (miss_done_q.size() >= MISSU_ENTRIES) begin
                check_value("miss entry reuse",
                    32'(cyc >= miss_done_q[miss_done_q.size() - MISSU_ENTRIES] + REFILL_LAT),
                    32'd1);
            end
            miss_done_q.push_back(cyc);
            fill_edge[line] = cyc + REFILL_LAT - 1;  // Line is filled from here on
            line_done[line] = cyc;
        end
        if (sb_ep[t] >= 0) begin
            if (ep_last.exists(sb_ep[t])) begin
                check_value("replay order", 32'(sb_seq[t]),
                            32'((ep_last[sb_ep[t]] + 1) % ep_cnt[sb_ep[t]]));
            end
            ep_last[sb_ep[t]] = sb_seq[t];
        end
        sb_addr.delete(t);
    endtask

    initial begin
        int            idx;
        int            limit;
        int            t;
        int            ep_id;
        int            busy_from;
        int            busy_to;
        bit            took;
        bit            busy_now;
        bit            busy_prev;
        bit            ready_low;
        logic [LW-1:0] l;
        i_reset_n   = 1'b0;
        i_req_valid = 1'b0;
        i_req_tag   = '0;
        i_req_base  = '0;
        i_req_inst  = '0;
        i_miss      = 1'b0;
        i_l1d_busy  = 1'b0;
        idx         = 0;
        ep_id       = 0;
        busy_from   = 1;
        busy_to     = 0;
        busy_prev   = 1'b0;
        ready_low   = 1'b0;
        cyc         = 0;
        read_trace();
        limit = 200 * n_lines;
        repeat (16) @(posedge i_clk);
        i_reset_n <= 1'b1;

        // Idle after reset
        repeat (4) begin
            @(posedge i_clk);
            cyc++;
            busy_at[cyc] = 0;
            check_value("o_done_valid", 32'(o_done_valid), 32'd0);
            check_value("o_req_ready", 32'(o_req_ready), 32'd1);
        end

        while (idx < n_lines || sb_addr.num() > 0) begin
            @(posedge i_clk);
            cyc++;
            if (cyc > limit) report_fail("timeout: loads still in flight at the cycle limit");
            if (o_done_valid) check_done();
            if (!o_req_ready) ready_low = 1'b1;
            took = i_req_valid && o_req_ready;
            if (took && tr_bs[idx] <= tr_be[idx]) begin
                busy_from = cyc + tr_bs[idx];
                busy_to   = cyc + tr_be[idx];
            end
            busy_now = cyc >= busy_from && cyc <= busy_to;
            if (busy_now && !busy_prev) begin
                ep_id++;
                ep_cnt[ep_id] = 0;
            end
            busy_prev    = busy_now;
            busy_at[cyc] = busy_now;
            if (took) begin
                t = int'(tr_tag[idx]);
                l = tr_addr[idx][31:OFF];
                sb_addr[t] = tr_addr[idx];
                sb_line[t] = l;
                sb_cap[t]  = cyc;
                sb_miss[t] = (tr_miss[idx] != 0 && !seen_line.exists(l)) ? 1 : 0;
                sb_wait[t] = (tr_miss[idx] != 0 && sb_miss[t] == 0) ? 1 : 0;
                sb_fast[t] = (!busy_now && tr_miss[idx] == 0) ? 1 : 0;
                if (tr_miss[idx] != 0) seen_line[l] = 1'b1;
                if (busy_now) begin
                    sb_ep[t]  = ep_id;
                    sb_seq[t] = ep_cnt[ep_id];
                    ep_cnt[ep_id]++;
                end else begin
                    sb_ep[t] = -1;
                end
            end
            // Line seen by stage 2 in the coming cycle
            if (u_dut.rq_valid) l = u_dut.rq_addr[31:OFF];
            else if (took) l = tr_addr[idx][31:OFF];
            else l = '0;
            i_l1d_busy <= busy_now;
            i_miss     <= miss_line.exists(l) && !(fill_edge.exists(l) && cyc >= fill_edge[l]);
            if (took) idx++;
            if (idx < n_lines && !sb_addr.exists(int'(tr_tag[idx]))) begin
                i_req_valid <= 1'b1;
                i_req_tag   <= tr_tag[idx][3:0];
                i_req_base  <= tr_base[idx];
                i_req_inst  <= tr_inst[idx];
            end else begin
                i_req_valid <= 1'b0;
            end
        end

        check_value("o_req_ready seen low", 32'(ready_low), 32'd1);
        if (sb_addr.num() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            report_fail("loads left in the scoreboard at the end");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/lsu_replay_trace.txt
# tag base inst miss busy_start busy_end expected_addr
# busy window in cycles after the load is taken, end below start means none
0 00001000 01002083 0 1 0 00001010
1 00002004 04306013 0 1 0 00002044
2 00003000 ff802083 0 1 0 00002ff8
3 00004000 00402083 0 0 5 00004004
3 00010000 01002083 1 1 0 00010010
4 00010020 00402083 1 1 0 00010024
5 00020000 00002083 1 1 0 00020000
6 00030000 00002083 1 1 0 00030000
7 00040000 00002083 1 1 0 00040000
8 00050000 04306013 1 1 0 00050040
8 00006000 00002083 0 0 20 00006000
9 00006100 01002083 0 1 0 00006110
a 00006200 00402083 0 1 0 00006204
b 00006300 ff802083 0 1 0 000062f8
c 00006400 04306013 0 1 0 00006440
d 00006500 00002083 0 1 0 00006500
e 00006600 01002083 0 1 0 00006610
f 00006700 00002083 0 1 0 00006700
0 00006800 00002083 0 1 0 00006800
1 00006900 00402083 0 1 0 00006904

//--- src.f
rtl/lsu_replay_pkg.sv
rtl/lsu_issue_sel.sv
rtl/lsu_addr_stage.sv
rtl/lsu_replay_queue.sv
rtl/lsu_miss_tracker.sv
rtl/lsu_replay_top.sv
testbench/tb_lsu_replay.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_lsu_replay
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
